/* Makefile */
SIM      ?= verilator
TOP      := tb_lsu
FILELIST := sim.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* lsu_fifo.sv */
//**************************************************
// lsu fifo
// generic synchronous fifo, circular buffer with
// read/write pointers and an occupancy count,
// valid/ready handshake on push and pop
//**************************************************

module lsu_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_valid_i,
    output logic             push_ready_o,
    input  logic [WIDTH-1:0] push_data_i,
    output logic             pop_valid_o,
    input  logic             pop_ready_i,
    output logic [WIDTH-1:0] pop_data_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    // pointer wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready_o = (count != CNT_W'(DEPTH));
    assign pop_valid_o  = (count != '0);
    assign push_fire    = push_valid_i && push_ready_o;
    assign pop_fire     = pop_valid_o && pop_ready_i;

    // head entry straight from the array
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count alone
            case ({push_fire, pop_fire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

/* lsu_issue.sv */
//**************************************************
// lsu issue stage
// sends the head request out on AR, or on AW and W,
// pushes the tag of each load and keeps count of
// stores still waiting for their B response
//**************************************************

module lsu_issue (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              ar_valid_o,
    input  logic              ar_ready_i,
    output lsu_pkg::lsu_ar_t  ar_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output lsu_pkg::lsu_aw_t  aw_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    output lsu_pkg::lsu_w_t   w_o,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    output logic              tag_valid_o,
    input  logic              tag_ready_i,
    output lsu_pkg::lsu_tag_t tag_o,
    output logic              stores_busy_o
);
    import lsu_pkg::*;

    logic                       is_load;
    logic                       is_store;
    logic                       load_fire;
    logic                       store_room;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       store_done;
    logic                       b_fire;
    logic                       aw_done;
    logic                       w_done;
    logic [LSU_STORE_CNT_W-1:0] store_cnt;

    assign is_load  = req_valid_i && !req_i.is_store;
    assign is_store = req_valid_i && req_i.is_store;

    // load path
    // AR only while the tag queue has room, so both land on one edge
    assign ar_valid_o  = is_load && tag_ready_i;
    assign ar_o.addr   = req_i.addr;
    assign load_fire   = ar_valid_o && ar_ready_i;
    assign tag_valid_o = load_fire;

    assign tag_o.rd          = req_i.rd;
    assign tag_o.commit_id   = req_i.commit_id;
    assign tag_o.size        = req_i.size;
    assign tag_o.is_unsigned = req_i.is_unsigned;
    assign tag_o.offset      = req_i.addr[1:0];

    // store path
    assign store_room = (store_cnt < LSU_STORE_CNT_W'(LSU_MAX_STORES));
    assign aw_valid_o = is_store && store_room && !aw_done;
    assign w_valid_o  = is_store && store_room && !w_done;
    assign aw_o.addr  = req_i.addr;
    assign w_o.data   = req_i.wdata;
    assign w_o.strb   = req_i.wstrb;

    assign aw_fire    = aw_valid_o && aw_ready_i;
    assign w_fire     = w_valid_o && w_ready_i;
    // both halves done, either earlier or on this edge
    assign store_done = is_store && store_room &&
                        (aw_done || aw_fire) && (w_done || w_fire);

    assign b_ready_o     = 1'b1;
    assign b_fire        = b_valid_i && b_ready_o;
    assign stores_busy_o = (store_cnt != '0);

    // the head leaves the queue once fully issued
    assign req_ready_o = load_fire || store_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (store_done) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_done <= 1'b1;
            end
            if (w_fire) begin
                w_done <= 1'b1;
            end
        end
    end

    // stores awaiting B
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_cnt <= '0;
        end else begin
            case ({store_done, b_fire})
                2'b10: begin
                    store_cnt <= store_cnt + 1'b1;
                end
                2'b01: begin
                    store_cnt <= store_cnt - 1'b1;
                end
                default: begin
                    store_cnt <= store_cnt;
                end
            endcase
        end
    end

endmodule

/* lsu_load_align.sv */
//**************************************************
// lsu load align
// pairs read data with the oldest load tag, picks
// and extends the byte or halfword, and holds the
// result in the writeback register
//**************************************************

module lsu_load_align (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              r_valid_i,
    output logic              r_ready_o,
    input  lsu_pkg::lsu_r_t   r_i,
    input  logic              tag_valid_i,
    output logic              tag_ready_o,
    input  lsu_pkg::lsu_tag_t tag_i,
    output logic              wb_valid_o,
    input  logic              wb_ready_i,
    output lsu_pkg::lsu_wb_t  wb_o,
    output logic              wb_busy_o
);
    import lsu_pkg::*;

    lsu_word_u             word_u;
    logic [7:0]            sel_byte;
    logic [15:0]           sel_half;
    logic [LSU_DATA_W-1:0] load_data;
    logic                  r_fire;
    logic                  load_fire;
    logic                  wb_valid_q;
    lsu_wb_t               wb_q;

    // register free, or emptying on this edge
    assign r_ready_o   = !wb_valid_q || wb_ready_i;
    assign r_fire      = r_valid_i && r_ready_o;
    // read data always belongs to the oldest tag
    assign load_fire   = r_fire && tag_valid_i;
    assign tag_ready_o = load_fire;

    // lane select and extension
    always_comb begin
        word_u   = r_i.data;
        sel_byte = word_u.bytes[tag_i.offset];
        sel_half = word_u.halves[tag_i.offset[1]];
        case (tag_i.size)
            LSU_SIZE_BYTE: begin
                if (tag_i.is_unsigned) begin
                    load_data = {{(LSU_DATA_W - 8){1'b0}}, sel_byte};
                end else begin
                    load_data = {{(LSU_DATA_W - 8){sel_byte[7]}}, sel_byte};
                end
            end
            LSU_SIZE_HALF: begin
                if (tag_i.is_unsigned) begin
                    load_data = {{(LSU_DATA_W - 16){1'b0}}, sel_half};
                end else begin
                    load_data = {{(LSU_DATA_W - 16){sel_half[15]}}, sel_half};
                end
            end
            default: begin
                load_data = r_i.data;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_q <= 1'b0;
        end else if (load_fire) begin
            wb_valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_q <= 1'b0;
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (load_fire) begin
            wb_q.rd        <= tag_i.rd;
            wb_q.commit_id <= tag_i.commit_id;
            wb_q.data      <= load_data;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb_q;
    assign wb_busy_o  = wb_valid_q;

endmodule

/* lsu_pkg.sv */
//**************************************************
// lsu package
// widths, queue depths, access size encoding and
// the payload structs of every channel of the
// load/store unit
//**************************************************

package lsu_pkg;

    // bus and register file widths
    localparam int LSU_ADDR_W      = 32;
    localparam int LSU_DATA_W      = 32;
    localparam int LSU_STRB_W      = 4;
    localparam int LSU_REG_ADDR_W  = 5;
    localparam int LSU_COMMIT_ID_W = 3;

    // queue depths and outstanding limits
    localparam int LSU_REQ_DEPTH   = 4;
    localparam int LSU_LOAD_DEPTH  = 4;
    localparam int LSU_MAX_STORES  = 4;
    localparam int LSU_STORE_CNT_W = 3;

    typedef enum logic [1:0] {
        LSU_SIZE_BYTE = 2'b00,
        LSU_SIZE_HALF = 2'b01,
        LSU_SIZE_WORD = 2'b10
    } lsu_size_e;

    // request from the core, store data already in its byte lanes
    typedef struct packed {
        logic                       is_store;
        lsu_size_e                  size;
        logic                       is_unsigned;
        logic [LSU_REG_ADDR_W-1:0]  rd;
        logic [LSU_COMMIT_ID_W-1:0] commit_id;
        logic [LSU_ADDR_W-1:0]      addr;
        logic [LSU_DATA_W-1:0]      wdata;
        logic [LSU_STRB_W-1:0]      wstrb;
    } lsu_req_t;

    // what a load needs to remember until its read data returns
    typedef struct packed {
        logic [LSU_REG_ADDR_W-1:0]  rd;
        logic [LSU_COMMIT_ID_W-1:0] commit_id;
        lsu_size_e                  size;
        logic                       is_unsigned;
        logic [1:0]                 offset;
    } lsu_tag_t;

    typedef struct packed {
        logic [LSU_ADDR_W-1:0] addr;
    } lsu_ar_t;

    typedef struct packed {
        logic [LSU_ADDR_W-1:0] addr;
    } lsu_aw_t;

    typedef struct packed {
        logic [LSU_DATA_W-1:0] data;
        logic [LSU_STRB_W-1:0] strb;
    } lsu_w_t;

    typedef struct packed {
        logic [LSU_DATA_W-1:0] data;
    } lsu_r_t;

    typedef struct packed {
        logic [LSU_REG_ADDR_W-1:0]  rd;
        logic [LSU_COMMIT_ID_W-1:0] commit_id;
        logic [LSU_DATA_W-1:0]      data;
    } lsu_wb_t;

    // read word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } lsu_word_u;

endpackage

/* lsu_top.sv */
//**************************************************
// lsu top
// load/store unit: request queue, issue stage,
// load tag queue and load align/writeback stage
//**************************************************

module lsu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  lsu_pkg::lsu_req_t req_i,
    output logic              ar_valid_o,
    input  logic              ar_ready_i,
    output lsu_pkg::lsu_ar_t  ar_o,
    input  logic              r_valid_i,
    output logic              r_ready_o,
    input  lsu_pkg::lsu_r_t   r_i,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output lsu_pkg::lsu_aw_t  aw_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    output lsu_pkg::lsu_w_t   w_o,
    input  logic              b_valid_i,
    output logic              b_ready_o,
    output logic              wb_valid_o,
    input  logic              wb_ready_i,
    output lsu_pkg::lsu_wb_t  wb_o,
    output logic              busy_o
);
    import lsu_pkg::*;

    // queued request toward issue
    logic     head_valid;
    logic     head_ready;
    lsu_req_t head_req;

    // load tags, issue side and align side
    logic     tag_push_valid;
    logic     tag_push_ready;
    lsu_tag_t tag_push;
    logic     tag_pop_valid;
    logic     tag_pop_ready;
    lsu_tag_t tag_pop;

    logic     stores_busy;
    logic     wb_busy;

    lsu_fifo #(
        .DEPTH(LSU_REQ_DEPTH),
        .WIDTH($bits(lsu_req_t))
    ) u_req_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_valid_i(req_valid_i),
        .push_ready_o(req_ready_o),
        .push_data_i (req_i),
        .pop_valid_o (head_valid),
        .pop_ready_i (head_ready),
        .pop_data_o  (head_req)
    );

    lsu_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (head_valid),
        .req_ready_o  (head_ready),
        .req_i        (head_req),
        .ar_valid_o   (ar_valid_o),
        .ar_ready_i   (ar_ready_i),
        .ar_o         (ar_o),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .aw_o         (aw_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .w_o          (w_o),
        .b_valid_i    (b_valid_i),
        .b_ready_o    (b_ready_o),
        .tag_valid_o  (tag_push_valid),
        .tag_ready_i  (tag_push_ready),
        .tag_o        (tag_push),
        .stores_busy_o(stores_busy)
    );

    lsu_fifo #(
        .DEPTH(LSU_LOAD_DEPTH),
        .WIDTH($bits(lsu_tag_t))
    ) u_tag_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_valid_i(tag_push_valid),
        .push_ready_o(tag_push_ready),
        .push_data_i (tag_push),
        .pop_valid_o (tag_pop_valid),
        .pop_ready_i (tag_pop_ready),
        .pop_data_o  (tag_pop)
    );

    lsu_load_align u_load_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .r_valid_i  (r_valid_i),
        .r_ready_o  (r_ready_o),
        .r_i        (r_i),
        .tag_valid_i(tag_pop_valid),
        .tag_ready_o(tag_pop_ready),
        .tag_i      (tag_pop),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_o       (wb_o),
        .wb_busy_o  (wb_busy)
    );

    // anything queued, in flight or waiting to write back
    assign busy_o = head_valid | tag_pop_valid | stores_busy | wb_busy;

endmodule

/* sim.f */
lsu_pkg.sv
lsu_fifo.sv
lsu_issue.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

/* tb_lsu.sv */
//**************************************************
// lsu testbench
// drives requests into the load/store unit, models
// expected writebacks and checks them by assertions
//**************************************************

module tb_lsu;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int TIMEOUT = 2000;
    localparam int N_WORDS = 16;

    logic      clk;
    logic      rst_n;
    logic      req_valid_i;
    logic      req_ready_o;
    lsu_req_t  req_i;
    logic      ar_valid_o;
    logic      ar_ready;
    lsu_ar_t   ar_o;
    logic      r_valid;
    logic      r_ready_o;
    lsu_r_t    r_data;
    logic      aw_valid_o;
    logic      aw_ready;
    lsu_aw_t   aw_o;
    logic      w_valid_o;
    logic      w_ready;
    lsu_w_t    w_o;
    logic      b_valid;
    logic      b_ready_o;
    logic      wb_valid_o;
    logic      wb_ready_i;
    lsu_wb_t   wb_o;
    logic      busy_o;

    lsu_wb_t     exp_q [$];
    lsu_wb_t     exp_head;
    logic        exp_empty;
    logic [31:0] ref_mem [N_WORDS];
    logic [2:0]  next_cid;
    logic [3:0]  word_idx;
    logic        saw_full;
    logic        stall_en;
    logic        chk_reset;
    logic        chk_stress;
    logic        chk_idle;
    logic        wb_fire_s;
    logic        ar_fire_s;
    logic        b_fire_s;
    int          errors;
    int          loads_sent;
    int          stores_sent;
    int          wb_seen;
    int          b_seen;
    int          outstanding;
    int          max_out;
    int          test_num;

    lsu_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .req_i      (req_i),
        .ar_valid_o (ar_valid_o),
        .ar_ready_i (ar_ready),
        .ar_o       (ar_o),
        .r_valid_i  (r_valid),
        .r_ready_o  (r_ready_o),
        .r_i        (r_data),
        .aw_valid_o (aw_valid_o),
        .aw_ready_i (aw_ready),
        .aw_o       (aw_o),
        .w_valid_o  (w_valid_o),
        .w_ready_i  (w_ready),
        .w_o        (w_o),
        .b_valid_i  (b_valid),
        .b_ready_o  (b_ready_o),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_o       (wb_o),
        .busy_o     (busy_o)
    );

    tb_lsu_mem u_mem (
        .clk       (clk),
        .ar_valid_i(ar_valid_o),
        .ar_ready_o(ar_ready),
        .ar_i      (ar_o),
        .r_valid_o (r_valid),
        .r_ready_i (r_ready_o),
        .r_o       (r_data),
        .aw_valid_i(aw_valid_o),
        .aw_ready_o(aw_ready),
        .aw_i      (aw_o),
        .w_valid_i (w_valid_o),
        .w_ready_o (w_ready),
        .w_i       (w_o),
        .b_valid_o (b_valid),
        .b_ready_i (b_ready_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    a_reset_state: assert property (@(posedge clk) chk_reset |->
        !ar_valid_o && !aw_valid_o && !w_valid_o && !wb_valid_o && !busy_o &&
        req_ready_o && r_ready_o && b_ready_o)
    else begin
        errors++;
        $display("outputs are not in their reset state at %0t", $time);
    end

    a_wb_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o && wb_ready_i |-> !exp_empty && wb_o == exp_head)
    else begin
        errors++;
        $display("FAIL %0t wb_o got %h expected %h", $time, $sampled(wb_o),
                 $sampled(exp_head));
    end

    a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o))
    else begin
        errors++;
        $display("writeback dropped or changed while stalled at %0t", $time);
    end

    a_stress: assert property (@(posedge clk) chk_stress |-> saw_full && max_out > 1)
    else begin
        errors++;
        $display("queue never filled or loads never overlapped, max outstanding %0d",
                 max_out);
    end

    a_idle: assert property (@(posedge clk) chk_idle |-> !busy_o)
    else begin
        errors++;
        $display("FAIL %0t busy_o got %b expected 0", $time, $sampled(busy_o));
    end

    a_count: assert property (@(posedge clk) chk_idle |-> wb_seen == loads_sent)
    else begin
        errors++;
        $display("%0d writebacks seen for %0d loads", wb_seen, loads_sent);
    end

    // expected load result from the byte and halfword lanes
    function automatic logic [31:0] extract(input logic [31:0] word, input lsu_size_e size,
                                            input logic [1:0] off, input logic uns);
        lsu_word_u   w;
        logic [7:0]  b;
        logic [15:0] h;
        w = word;
        b = w.bytes[off];
        h = w.halves[off[1]];
        if (size == LSU_SIZE_BYTE) begin
            return uns ? {24'h0, b} : {{24{b[7]}}, b};
        end else if (size == LSU_SIZE_HALF) begin
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        end
        return word;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $finish;
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %s done, %0d errors so far", test_num, name, errors);
    endtask

    // reference model update on acceptance
    task automatic model_accept(input lsu_req_t req);
        lsu_wb_t exp;
        if (req.is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wstrb[i]) begin
                    ref_mem[req.addr[5:2]][8*i +: 8] = req.wdata[8*i +: 8];
                end
            end
            stores_sent++;
        end else begin
            exp.rd        = req.rd;
            exp.commit_id = req.commit_id;
            exp.data      = extract(ref_mem[req.addr[5:2]], req.size, req.addr[1:0],
                                    req.is_unsigned);
            exp_q.push_back(exp);
            loads_sent++;
        end
    endtask

    task automatic send_req(input logic is_store, input lsu_size_e size, input logic uns,
                            input logic [3:0] idx, input logic [1:0] off,
                            input logic [3:0] strb);
        lsu_req_t req;
        logic     accepted;
        int       t;
        req.is_store    = is_store;
        req.size        = size;
        req.is_unsigned = uns;
        req.rd          = 5'($urandom);
        req.commit_id   = next_cid;
        req.addr        = {26'($urandom), idx, off};
        req.wdata       = $urandom;
        req.wstrb       = strb;
        next_cid        = next_cid + 3'd1;
        req_i           = req;
        req_valid_i     = 1'b1;
        accepted        = 1'b0;
        t               = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready_o;
            @(posedge clk);
            t++;
            if (!accepted && t > TIMEOUT) begin
                abort_run("request was never accepted");
            end
        end
        model_accept(req);
        #1;
        req_valid_i = 1'b0;
    endtask

    // every load written back and every store answered on B
    task automatic wait_drain();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                abort_run("unit did not drain");
            end
        end while (!exp_empty || b_seen != stores_sent);
        @(posedge clk);
        #1;
    endtask

    // handshake monitor, sampled mid cycle and applied on the edge
    initial begin
        exp_empty   = 1'b1;
        exp_head    = '0;
        saw_full    = 1'b0;
        wb_seen     = 0;
        b_seen      = 0;
        outstanding = 0;
        max_out     = 0;
        forever begin
            @(negedge clk);
            wb_fire_s = wb_valid_o && wb_ready_i;
            ar_fire_s = ar_valid_o && ar_ready;
            b_fire_s  = b_valid && b_ready_o;
            if (rst_n && !req_ready_o) begin
                saw_full = 1'b1;
            end
            @(posedge clk);
            if (wb_fire_s) begin
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
                wb_seen++;
                outstanding--;
            end
            if (ar_fire_s) begin
                outstanding++;
            end
            if (b_fire_s) begin
                b_seen++;
            end
            if (outstanding > max_out) begin
                max_out = outstanding;
            end
            #2;
            exp_empty = (exp_q.size() == 0);
            if (!exp_empty) begin
                exp_head = exp_q[0];
            end
        end
    end

    // writeback back-pressure in random stretches
    initial begin
        int stall_left;
        wb_ready_i = 1'b1;
        stall_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!stall_en) begin
                wb_ready_i = 1'b1;
            end else if (stall_left == 0) begin
                wb_ready_i = !wb_ready_i;
                stall_left = $urandom % 6;
            end else begin
                stall_left--;
            end
        end
    end

    initial begin
        void'($urandom(32'h70d2b268));
        rst_n       = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        next_cid    = '0;
        word_idx    = '0;
        stall_en    = 1'b0;
        chk_reset   = 1'b0;
        chk_stress  = 1'b0;
        chk_idle    = 1'b0;
        errors      = 0;
        loads_sent  = 0;
        stores_sent = 0;
        test_num    = 0;
        for (int i = 0; i < N_WORDS; i++) begin
            ref_mem[i] = 32'h9e3779b9 * 32'(i + 1);
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        chk_reset = 1'b1;
        @(posedge clk);
        #1;
        chk_reset = 1'b0;
        report_test("reset state");

        word_idx = 4'($urandom);
        send_req(1'b1, LSU_SIZE_WORD, 1'b0, word_idx, 2'd0, 4'hf);
        send_req(1'b0, LSU_SIZE_WORD, 1'b0, word_idx, 2'd0, 4'h0);
        wait_drain();
        report_test("word store then load");

        // byte lanes at every offset, halfword lanes at 0 and 2
        for (int off = 0; off < 4; off++) begin
            for (int uns = 0; uns < 2; uns++) begin
                send_req(1'b0, LSU_SIZE_BYTE, 1'(uns), 4'($urandom), 2'(off), 4'h0);
            end
        end
        for (int off = 0; off < 4; off += 2) begin
            for (int uns = 0; uns < 2; uns++) begin
                send_req(1'b0, LSU_SIZE_HALF, 1'(uns), 4'($urandom), 2'(off), 4'h0);
            end
        end
        wait_drain();
        report_test("byte and halfword extension");

        for (int i = 0; i < 6; i++) begin
            word_idx = 4'($urandom);
            send_req(1'b1, LSU_SIZE_WORD, 1'b0, word_idx, 2'd0, 4'($urandom) | 4'b0001);
            send_req(1'b0, LSU_SIZE_WORD, 1'b0, word_idx, 2'd0, 4'h0);
        end
        wait_drain();
        report_test("partial strobe merge");

        // fill and overlap seen in this test only
        saw_full = 1'b0;
        max_out  = 0;
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_req(($urandom % 3) == 0, lsu_size_e'(2'($urandom % 3)), 1'($urandom),
                     4'($urandom), 2'($urandom), 4'($urandom));
        end
        stall_en = 1'b0;
        wait_drain();
        chk_stress = 1'b1;
        @(posedge clk);
        #1;
        chk_stress = 1'b0;
        report_test("random stalls");

        chk_idle = 1'b1;
        @(posedge clk);
        #1;
        chk_idle = 1'b0;
        report_test("drain to idle");

        $display("tests %0d, loads %0d, writebacks %0d, errors %0d", test_num,
                 loads_sent, wb_seen, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tb_lsu_mem.sv */
//**************************************************
// lsu memory model
// AXI-lite style memory with random ready and
// response delays, in order reads, strobed writes
//**************************************************

module tb_lsu_mem (
    input  logic             clk,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    input  lsu_pkg::lsu_ar_t ar_i,
    output logic             r_valid_o,
    input  logic             r_ready_i,
    output lsu_pkg::lsu_r_t  r_o,
    input  logic             aw_valid_i,
    output logic             aw_ready_o,
    input  lsu_pkg::lsu_aw_t aw_i,
    input  logic             w_valid_i,
    output logic             w_ready_o,
    input  lsu_pkg::lsu_w_t  w_i,
    output logic             b_valid_o,
    input  logic             b_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int N_WORDS = 16;

    logic [31:0] mem [N_WORDS];
    logic [31:0] rd_q [$];
    logic        ar_fire;
    logic        r_fire;
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;
    logic        aw_got;
    logic        w_got;
    logic [3:0]  ar_idx;
    logic [3:0]  aw_idx;
    lsu_w_t      w_hold;
    int          b_pend;

    // ready or valid in about three cycles of four
    function automatic logic draw_ready();
        return ($urandom % 4) != 0;
    endfunction

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        aw_got     = 1'b0;
        w_got      = 1'b0;
        aw_idx     = '0;
        w_hold     = '0;
        b_pend     = 0;
        for (int i = 0; i < N_WORDS; i++) begin
            mem[i] = 32'h9e3779b9 * 32'(i + 1);
        end
        forever begin
            // handshakes are settled mid cycle
            @(negedge clk);
            ar_fire = ar_valid_i && ar_ready_o;
            ar_idx  = ar_i.addr[5:2];
            r_fire  = r_valid_o && r_ready_i;
            aw_fire = aw_valid_i && aw_ready_o;
            w_fire  = w_valid_i && w_ready_o;
            b_fire  = b_valid_o && b_ready_i;
            if (aw_fire) begin
                aw_got = 1'b1;
                aw_idx = aw_i.addr[5:2];
            end
            if (w_fire) begin
                w_got  = 1'b1;
                w_hold = w_i;
            end
            @(posedge clk);
            if (aw_got && w_got) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_hold.strb[i]) begin
                        mem[aw_idx][8*i +: 8] = w_hold.data[8*i +: 8];
                    end
                end
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_pend++;
            end
            if (ar_fire) begin
                rd_q.push_back(mem[ar_idx]);
            end
            if (r_fire) begin
                void'(rd_q.pop_front());
            end
            if (b_fire) begin
                b_pend--;
            end
            #1;
            ar_ready_o = draw_ready();
            aw_ready_o = !aw_got && draw_ready();
            w_ready_o  = !w_got && draw_ready();
            // a raised valid holds until it transfers
            if (r_fire || !r_valid_o) begin
                r_valid_o = (rd_q.size() != 0) && draw_ready();
                if (r_valid_o) begin
                    r_o.data = rd_q[0];
                end
            end
            if (b_fire || !b_valid_o) begin
                b_valid_o = (b_pend > 0) && draw_ready();
            end
        end
    end

endmodule
